//--- compile.f
object_pkg.sv
motion_axis.sv
pixel_render.sv
object_engine.sv
tb_object_engine.sv

//--- motion_axis.sv
`timescale 1ns/1ns

module motion_axis import object_pkg::*;
#(
    parameter int      AXIS_MIN     = SCREEN_MIN_X,
    parameter int      AXIS_MAX     = SCREEN_MAX_X,
    parameter int      TILE_SIZE    = TILE_W,
    parameter coord_t  START_POS    = START_X,
    parameter facing_e FACING_RESET = FACE_POS
)
(
    input  logic        clk,
    input  logic        reset,
    input  axis_cmd_t   cmd,
    output axis_state_t axis
);

    motion_e             state_reg, state_next;
    logic [TIME_W-1:0]   count_reg, count_next;        // countdown to the next step
    logic [TIME_W-1:0]   start_reg, start_next;        // reload value, sets the speed
    coord_t              pos_reg, pos_next;
    facing_e             facing_reg, facing_next;

    logic room_neg;                                    // a step towards the minimum is allowed
    logic room_pos;                                    // a step towards the maximum is allowed
    logic one_btn;                                     // exactly one button held
    logic same_btn;                                    // button of the current direction
    logic opp_btn;                                     // button against the current direction

    assign room_neg = (int'(pos_reg) > AXIS_MIN) || cmd.no_boundary;
    assign room_pos = (int'(pos_reg) + 1 < AXIS_MAX - TILE_SIZE) || cmd.no_boundary;
    assign one_btn  = cmd.neg ^ cmd.pos;
    assign same_btn = (state_reg == MOVE_NEG) ? cmd.neg : cmd.pos;
    assign opp_btn  = (state_reg == MOVE_NEG) ? cmd.pos : cmd.neg;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state_reg  <= IDLE;
            count_reg  <= '0;
            start_reg  <= '0;
            pos_reg    <= START_POS;
            facing_reg <= FACING_RESET;
        end
        else
        begin
            state_reg  <= state_next;
            count_reg  <= count_next;
            start_reg  <= start_next;
            pos_reg    <= pos_next;
            facing_reg <= facing_next;
        end
    end

    always_comb
    begin
        state_next  = state_reg;                       // hold by default
        count_next  = count_reg;
        start_next  = start_reg;
        pos_next    = pos_reg;
        facing_next = facing_reg;

        if (cmd.load)
        begin
            pos_next = cmd.load_value;                 // load wins over the fsm
        end
        else
        begin
            if (one_btn)
            begin
                facing_next = cmd.neg ? FACE_NEG : FACE_POS;
            end

            case (state_reg)
                IDLE:
                begin
                    if (cmd.neg && !cmd.pos && room_neg)
                    begin
                        state_next = MOVE_NEG;
                        count_next = TIME_START;       // start at the slowest speed
                        start_next = TIME_START;
                    end
                    else if (cmd.pos && !cmd.neg && room_pos)
                    begin
                        state_next = MOVE_POS;
                        count_next = TIME_START;
                        start_next = TIME_START;
                    end
                end

                MOVE_NEG, MOVE_POS:
                begin
                    if (count_reg != '0)
                    begin
                        count_next = count_reg - 1'b1; // wait for the next step
                    end
                    else
                    begin
                        if (state_reg == MOVE_NEG && room_neg)
                        begin
                            pos_next = pos_reg - 10'd1; // wraps to 1023 with no_boundary
                        end
                        else if (state_reg == MOVE_POS && room_pos)
                        begin
                            pos_next = pos_reg + 10'd1;
                        end

                        if (same_btn && start_reg > TIME_MIN)
                        begin
                            start_next = start_reg - TIME_STEP; // speed up
                        end
                        else if (opp_btn && !same_btn && start_reg < TIME_START)
                        begin
                            start_next = start_reg + TIME_STEP; // brake
                        end
                        count_next = start_next;       // reload for the next step
                    end

                    if (!same_btn || (cmd.neg && cmd.pos))
                    begin
                        state_next = IDLE;             // released or both held
                    end
                end

                default:
                begin
                    state_next = IDLE;
                end
            endcase
        end
    end

    assign axis = '{pos: pos_reg, facing: facing_reg};

    // reload value stays in the momentum window during motion
    a_start_range: assert property (@(posedge clk) disable iff (reset)
        state_reg != IDLE |-> (start_reg >= TIME_MIN && start_reg <= TIME_START));

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state_reg inside {IDLE, MOVE_NEG, MOVE_POS});

    // a step never carries the tile past the far edge
    a_pos_limit: assert property (@(posedge clk) disable iff (reset)
        (!cmd.no_boundary && !cmd.load && int'(pos_reg) <= AXIS_MAX - TILE_SIZE)
        |=> int'(pos_reg) <= AXIS_MAX - TILE_SIZE);

endmodule

//--- object_engine.sv
`timescale 1ns/1ns

module object_engine import object_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    btn_l,                             // move left
    input  logic    btn_r,                             // move right
    input  logic    btn_u,                             // move up
    input  logic    btn_d,                             // move down
    input  logic    no_boundary,                       // let the sprite wrap around the screen
    input  logic    trans_x_on,                        // load t_x into the x position
    input  logic    trans_y_on,                        // load t_y into the y position
    input  coord_t  t_x,
    input  coord_t  t_y,
    input  coord_t  x,                                 // current pixel from vga sync
    input  coord_t  y,
    input  logic    video_on,
    input  logic    object_enable,
    input  rgb_t    color_data,                        // texel read back from the sprite rom
    output rgb_t    rgb_out,
    output logic    object_on,
    output coord_t  o_x,                               // sprite top left corner
    output coord_t  o_y,
    output coord_t  row,                               // sprite rom address
    output coord_t  col,
    output facing_e x_facing,
    output facing_e y_facing
);

    axis_cmd_t   cmd_x, cmd_y;
    axis_state_t st_x, st_y;

    assign cmd_x = '{neg: btn_l, pos: btn_r, no_boundary: no_boundary,
                     load: trans_x_on, load_value: t_x};
    assign cmd_y = '{neg: btn_u, pos: btn_d, no_boundary: no_boundary,
                     load: trans_y_on, load_value: t_y};

    motion_axis #(
        .AXIS_MIN     (SCREEN_MIN_X),
        .AXIS_MAX     (SCREEN_MAX_X),
        .TILE_SIZE    (TILE_W),
        .START_POS    (START_X),
        .FACING_RESET (FACE_POS)                       // starts looking right
    ) u_axis_x (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd_x),
        .axis  (st_x)
    );

    motion_axis #(
        .AXIS_MIN     (SCREEN_MIN_Y),
        .AXIS_MAX     (SCREEN_MAX_Y),
        .TILE_SIZE    (TILE_H),
        .START_POS    (START_Y),
        .FACING_RESET (FACE_NEG)                       // starts looking up
    ) u_axis_y (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd_y),
        .axis  (st_y)
    );

    pixel_render u_render (
        .x             (x),
        .y             (y),
        .ax            (st_x),
        .ay            (st_y),
        .video_on      (video_on),
        .object_enable (object_enable),
        .color_data    (color_data),
        .row           (row),
        .col           (col),
        .rgb_out       (rgb_out),
        .object_on     (object_on)
    );

    assign o_x      = st_x.pos;
    assign o_y      = st_y.pos;
    assign x_facing = st_x.facing;
    assign y_facing = st_y.facing;

endmodule

//--- object_pkg.sv
package object_pkg;

    typedef logic [9:0]  coord_t;                      // pixel coordinate
    typedef logic [11:0] rgb_t;                        // 4 bits per channel

    // tile size in pixels
    localparam int TILE_W = 16;
    localparam int TILE_H = 16;

    // visible area of the vga frame
    localparam int SCREEN_MIN_X = 0;
    localparam int SCREEN_MAX_X = 640;
    localparam int SCREEN_MIN_Y = 16;                  // top band kept for the status line
    localparam int SCREEN_MAX_Y = 480;

    localparam coord_t START_X = 10'd150;              // position after reset
    localparam coord_t START_Y = 10'd240;

    // momentum timing, counted in clk cycles between one-pixel steps
    localparam int TIME_W = 20;
    localparam logic [TIME_W-1:0] TIME_START = 20'd40; // slowest step period
    localparam logic [TIME_W-1:0] TIME_STEP  = 20'd4;  // change per step
    localparam logic [TIME_W-1:0] TIME_MIN   = 20'd20; // fastest step period

    localparam rgb_t TRANSPARENT_RGB = 12'h6DE;        // background key in the sprite rom

    typedef enum logic [1:0] {
        IDLE     = 2'd0,                               // standing still
        MOVE_NEG = 2'd1,                               // left or up
        MOVE_POS = 2'd2                                // right or down
    } motion_e;

    typedef enum logic {
        FACE_NEG = 1'b0,                               // facing left or up
        FACE_POS = 1'b1                                // facing right or down
    } facing_e;

    typedef struct packed {
        logic   neg;                                   // left or up button
        logic   pos;                                   // right or down button
        logic   no_boundary;                           // ignore screen edges and wrap
        logic   load;                                  // direct position load
        coord_t load_value;
    } axis_cmd_t;

    typedef struct packed {
        coord_t  pos;                                  // top left corner on this axis
        facing_e facing;
    } axis_state_t;

endpackage

//--- pixel_render.sv
`timescale 1ns/1ns

module pixel_render import object_pkg::*;
(
    input  coord_t      x,
    input  coord_t      y,
    input  axis_state_t ax,
    input  axis_state_t ay,
    input  logic        video_on,
    input  logic        object_enable,
    input  rgb_t        color_data,
    output coord_t      row,
    output coord_t      col,
    output rgb_t        rgb_out,
    output logic        object_on
);

    logic   hit;                                       // pixel lies on the tile
    coord_t dx;                                        // offset inside the tile
    coord_t dy;

    assign hit = (int'(x) >= int'(ax.pos)) && (int'(x) <= int'(ax.pos) + TILE_W - 1) &&
                 (int'(y) >= int'(ay.pos)) && (int'(y) <= int'(ay.pos) + TILE_H - 1);

    assign dx = x - ax.pos;
    assign dy = y - ay.pos;

    // tile art faces right and up so the other directions read it mirrored
    assign col = (ax.facing == FACE_NEG) ? coord_t'(TILE_W - 1) - dx : dx;
    assign row = (ay.facing == FACE_POS) ? coord_t'(TILE_H - 1) - dy : dy;

    always_comb
    begin
        rgb_out   = '0;                                // black outside the sprite
        object_on = 1'b0;
        if (hit && video_on && object_enable)
        begin
            rgb_out   = color_data;
            object_on = (color_data != TRANSPARENT_RGB); // key colour is background
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the object engine testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_object_engine -f compile.f -o sim_object_engine
./obj_dir/sim_object_engine

//--- tb_object_engine.sv
`timescale 1ns/1ns

module tb_object_engine import object_pkg::*;
();

    typedef struct packed {
        logic [3:0]  btn;                              // l r u d
        logic        no_boundary;
        logic [1:0]  load;                             // trans_x_on, trans_y_on
        coord_t      load_value;                       // shared by t_x and t_y
        coord_t      px;                               // pixel under test
        coord_t      py;
        logic [1:0]  vid_en;                           // video_on, object_enable
        rgb_t        color;                            // texel returned by the rom model
        logic [15:0] hold;                             // rising edges before the check
    } stim_t;

    typedef struct packed {
        coord_t  o_x;
        coord_t  o_y;
        facing_e x_facing;
        facing_e y_facing;
        logic    chk_rc;                               // row and col only matter on the tile
        coord_t  row;
        coord_t  col;
        rgb_t    rgb;
        logic    on;
    } expect_t;

    logic    clk, reset;
    logic    btn_l, btn_r, btn_u, btn_d;
    logic    no_boundary, trans_x_on, trans_y_on;
    coord_t  t_x, t_y, x, y;
    logic    video_on, object_enable;
    rgb_t    color_data;
    rgb_t    rgb_out;
    logic    object_on;
    coord_t  o_x, o_y, row, col;
    facing_e x_facing, y_facing;

    stim_t   stim_q[$];
    expect_t exp_q[$];
    string   name_q[$];
    bit      table_ready;

    object_engine i_object_engine (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;                         // 100 MHz
    end

    task automatic add_vector(input string name, input logic [3:0] btn, input logic nb,
                              input logic [1:0] load, input coord_t lval, input coord_t px,
                              input coord_t py, input logic [1:0] vid_en, input rgb_t color,
                              input int hold, input coord_t ex, input coord_t ey,
                              input facing_e exf, input facing_e eyf, input logic chk_rc,
                              input coord_t erow, input coord_t ecol, input rgb_t ergb,
                              input logic eon);
        stim_t   s;
        expect_t e;
        s = '{btn: btn, no_boundary: nb, load: load, load_value: lval, px: px, py: py,
              vid_en: vid_en, color: color, hold: 16'(hold)};
        e = '{o_x: ex, o_y: ey, x_facing: exf, y_facing: eyf, chk_rc: chk_rc,
              row: erow, col: ecol, rgb: ergb, on: eon};
        name_q.push_back(name);
        stim_q.push_back(s);
        exp_q.push_back(e);
    endtask

    // expected columns: o_x o_y x_facing y_facing chk_rc row col rgb object_on
    task automatic build_table();
        add_vector("reset_state", 4'b0000, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 1,
                   10'd150, 10'd240, FACE_POS, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        // first step lands 41 edges after the edge that sees the press
        add_vector("right_step1", 4'b0100, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 42,
                   10'd151, 10'd240, FACE_POS, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("right_step2", 4'b0100, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 37,
                   10'd152, 10'd240, FACE_POS, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("right_step7", 4'b0100, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 129,
                   10'd157, 10'd240, FACE_POS, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("right_release", 4'b0000, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 100,
                   10'd157, 10'd240, FACE_POS, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("load_x_zero", 4'b0000, 1'b0, 2'b10, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 1,
                   10'd0, 10'd240, FACE_POS, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        // blocked by the left edge, only the facing changes
        add_vector("left_at_edge", 4'b1000, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 50,
                   10'd0, 10'd240, FACE_NEG, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("left_wrap", 4'b1000, 1'b1, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 42,
                   10'd1023, 10'd240, FACE_NEG, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("wrap_release", 4'b0000, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 2,
                   10'd1023, 10'd240, FACE_NEG, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("load_x_100", 4'b0000, 1'b0, 2'b10, 10'd100, 10'd0, 10'd0, 2'b00, 12'h000, 1,
                   10'd100, 10'd240, FACE_NEG, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("up_down_both", 4'b0011, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 50,
                   10'd100, 10'd240, FACE_NEG, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("down_2_steps", 4'b0001, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 79,
                   10'd100, 10'd242, FACE_NEG, FACE_POS, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("down_release", 4'b0000, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 2,
                   10'd100, 10'd242, FACE_NEG, FACE_POS, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        // offset (3,5) with x facing left and y facing down, both mirrored
        add_vector("render_hit", 4'b0000, 1'b0, 2'b00, 10'd0, 10'd103, 10'd247, 2'b11, 12'h0F0, 1,
                   10'd100, 10'd242, FACE_NEG, FACE_POS, 1'b1, 10'd10, 10'd12, 12'h0F0, 1'b1);
        add_vector("render_key", 4'b0000, 1'b0, 2'b00, 10'd0, 10'd103, 10'd247, 2'b11, 12'h6DE, 1,
                   10'd100, 10'd242, FACE_NEG, FACE_POS, 1'b1, 10'd10, 10'd12, 12'h6DE, 1'b0);
        add_vector("render_out", 4'b0000, 1'b0, 2'b00, 10'd0, 10'd116, 10'd247, 2'b11, 12'h0F0, 1,
                   10'd100, 10'd242, FACE_NEG, FACE_POS, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("render_blank", 4'b0000, 1'b0, 2'b00, 10'd0, 10'd103, 10'd247, 2'b01, 12'h0F0, 1,
                   10'd100, 10'd242, FACE_NEG, FACE_POS, 1'b1, 10'd10, 10'd12, 12'h000, 1'b0);
        add_vector("render_off", 4'b0000, 1'b0, 2'b00, 10'd0, 10'd103, 10'd247, 2'b10, 12'h0F0, 1,
                   10'd100, 10'd242, FACE_NEG, FACE_POS, 1'b1, 10'd10, 10'd12, 12'h000, 1'b0);
        // one edge of right and up turns both facings, release before any step
        add_vector("face_flip", 4'b0110, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 1,
                   10'd100, 10'd242, FACE_POS, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("face_release", 4'b0000, 1'b0, 2'b00, 10'd0, 10'd0, 10'd0, 2'b00, 12'h000, 1,
                   10'd100, 10'd242, FACE_POS, FACE_NEG, 1'b0, 10'd0, 10'd0, 12'h000, 1'b0);
        add_vector("render_plain", 4'b0000, 1'b0, 2'b00, 10'd0, 10'd103, 10'd247, 2'b11, 12'h0A5, 1,
                   10'd100, 10'd242, FACE_POS, FACE_NEG, 1'b1, 10'd5, 10'd3, 12'h0A5, 1'b1);
    endtask

    task automatic drive_inputs(input stim_t s);
        {btn_l, btn_r, btn_u, btn_d} = s.btn;
        no_boundary   = s.no_boundary;
        trans_x_on    = s.load[1];
        trans_y_on    = s.load[0];
        t_x           = s.load_value;
        t_y           = s.load_value;
        x             = s.px;
        y             = s.py;
        video_on      = s.vid_en[1];
        object_enable = s.vid_en[0];
        color_data    = s.color;
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Mismatch in %s: expected %0d (0x%0h), actual %0d (0x%0h)",
                     name, expected, expected, actual, actual);
            $display("test failed");
            $fatal(1, "output check did not match");
        end
    endtask

    task automatic check_outputs(input string nm, input expect_t e);
        check({nm, ".o_x"}, 32'(e.o_x), 32'(o_x));
        check({nm, ".o_y"}, 32'(e.o_y), 32'(o_y));
        check({nm, ".x_facing"}, 32'(e.x_facing), 32'(x_facing));
        check({nm, ".y_facing"}, 32'(e.y_facing), 32'(y_facing));
        check({nm, ".rgb_out"}, 32'(e.rgb), 32'(rgb_out));
        check({nm, ".object_on"}, 32'(e.on), 32'(object_on));
        if (e.chk_rc)
        begin
            check({nm, ".row"}, 32'(e.row), 32'(row));
            check({nm, ".col"}, 32'(e.col), 32'(col));
        end
    endtask

    initial
    begin
        reset = 1'b1;
        drive_inputs('0);                              // all inputs low, video blanked
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < stim_q.size(); i++)
        begin
            drive_inputs(stim_q[i]);                   // on the falling edge
            repeat (int'(stim_q[i].hold)) @(posedge clk);
            @(negedge clk);                            // outputs settled here
            check_outputs(name_q[i], exp_q[i]);
        end
        $display("test passed");
        $finish;
    end

    // ends a stuck run, limit scales with the table
    initial
    begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = 0;
        foreach (stim_q[i])
        begin
            limit_ns += longint'(stim_q[i].hold);
        end
        limit_ns = (limit_ns + 100) * 10;
        #(limit_ns);
        $display("watchdog expired: the stimulus table did not finish within %0d ns", limit_ns);
        $display("test failed");
        $fatal(1, "simulation timeout");
    end

endmodule
